// File: design/stream_dest_router.sv
// Destination router that steers each receive beat to its lane by tdest.

`include "stream_macros.svh"

module stream_dest_router (
    // Receive stream.
    input  stream_pkg::beat_t               rx_beat,
    input  logic                            rx_tvalid,
    output logic                            rx_tready,
    // Lane side.
    output stream_pkg::beat_t               lane_beat,
    output logic [stream_pkg::lanes-1:0]    lane_valid,
    input  logic [stream_pkg::lanes-1:0]    lane_ready
);
    import stream_pkg::*;

    localparam int DEST_W = `STREAM_TDEST_WIDTH;

    // ------------------------------
    // Destination decode
    // ------------------------------

    logic [lanes-1:0] dest_hit;  // One-hot lane select.

    always_comb begin
        dest_hit = '0;
        for (int i = 0; i < lanes; i++) begin
            dest_hit[i] = (rx_beat.tdest == DEST_W'(i));
        end
    end

    // ------------------------------
    // Beat fan-out
    // ------------------------------

    // Every lane sees the beat. Only the selected one sees valid.
    assign lane_beat = rx_beat;

    always_comb begin
        lane_valid = '0;
        for (int i = 0; i < lanes; i++) begin
            lane_valid[i] = rx_tvalid && dest_hit[i];
        end
    end

    // ------------------------------
    // Ready select
    // ------------------------------

    // A full lane stalls its own destination only.
    always_comb begin
        rx_tready = 1'b0;
        for (int i = 0; i < lanes; i++) begin
            if (dest_hit[i]) begin
                rx_tready = lane_ready[i];
            end
        end
    end

endmodule

// File: design/stream_macros.svh
// Width and depth defaults for the destination-sorted stream queue.

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// ------------------------------
// Beat field widths
// ------------------------------

// Data bytes carried in one beat.
`define STREAM_TDATA_BYTES 4

// Destination width. Every tdest value owns one lane.
`define STREAM_TDEST_WIDTH 2

`define STREAM_TUSER_WIDTH 4  // Sideband bits per beat.

`define STREAM_TID_WIDTH 4    // Stream identifier bits.

// ------------------------------
// Lane sizing
// ------------------------------

// Beats held by one lane before it stops accepting.
// Any value of 1 or more works. A power of two is not required.
`define STREAM_QUEUE_CAPACITY 8

`endif

// File: design/stream_packet_arbiter.sv
// Round-robin packet arbiter that drains the lanes onto one transmit stream.

`include "stream_macros.svh"

module stream_packet_arbiter (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    // Lane side.
    input  stream_pkg::beat_t [stream_pkg::lanes-1:0] q_beat,
    input  logic [stream_pkg::lanes-1:0]          q_valid,
    output logic [stream_pkg::lanes-1:0]          q_ready,
    // Transmit stream.
    output stream_pkg::beat_t                     tx_beat,
    output logic                                  tx_tvalid,
    input  logic                                  tx_tready
);
    import stream_pkg::*;

    localparam int IDX_W = `STREAM_TDEST_WIDTH;

    arb_state_t       state;
    logic [IDX_W-1:0] grant;        // Lane being forwarded.
    logic [IDX_W-1:0] last_served;  // Lane of the previous packet.
    logic [IDX_W-1:0] next_lane;    // Round-robin winner.
    logic [IDX_W-1:0] cand;
    logic             lane_found;
    logic             tx_done;      // Last beat of the packet leaves.

    // ------------------------------
    // Round-robin search
    // ------------------------------

    // Start after the lane served last. The index wraps by its width.
    always_comb begin
        next_lane  = last_served;
        lane_found = 1'b0;
        cand       = '0;
        for (int off = 1; off <= lanes; off++) begin
            cand = last_served + IDX_W'(off);
            if (!lane_found && q_valid[cand]) begin
                next_lane  = cand;
                lane_found = 1'b1;
            end
        end
    end

    // ------------------------------
    // Output mux
    // ------------------------------

    always_comb begin
        tx_beat   = q_beat[grant];
        tx_tvalid = 1'b0;
        q_ready   = '0;
        if (state == ARB_PACKET) begin
            tx_tvalid      = q_valid[grant];
            q_ready[grant] = tx_tready;  // Other lanes keep their heads.
        end
    end

    assign tx_done = tx_tvalid && tx_tready && tx_beat.tlast;

    // ------------------------------
    // Packet FSM
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state       <= ARB_IDLE;
            grant       <= '0;
            last_served <= IDX_W'(lanes - 1);  // Lane 0 goes first.
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (lane_found) begin
                        grant <= next_lane;
                        state <= ARB_PACKET;
                    end
                end
                ARB_PACKET: begin
                    // Grant holds until tlast, so packets never interleave.
                    if (tx_done) begin
                        last_served <= grant;
                        state       <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// File: design/stream_pkg.sv
// Stream beat struct, lane count and arbiter state enum.

`include "stream_macros.svh"

package stream_pkg;

    // ------------------------------
    // Lanes
    // ------------------------------

    // One lane per destination value.
    localparam int lanes = 2 ** `STREAM_TDEST_WIDTH;

    // ------------------------------
    // Beat
    // ------------------------------

    typedef struct packed {
        logic [`STREAM_TDATA_BYTES-1:0][7:0] tdata;  // Byte 0 is the lowest.
        logic [`STREAM_TDATA_BYTES-1:0]      tkeep;  // One bit per data byte.
        logic                                tlast;  // Closes a packet.
        logic [`STREAM_TDEST_WIDTH-1:0]      tdest;  // Selects the lane.
        logic [`STREAM_TUSER_WIDTH-1:0]      tuser;
        logic [`STREAM_TID_WIDTH-1:0]        tid;
    } beat_t;

    // ------------------------------
    // Arbiter
    // ------------------------------

    typedef enum logic {
        ARB_IDLE,    // Looking for a lane to serve.
        ARB_PACKET   // Forwarding one packet from the granted lane.
    } arb_state_t;

endpackage

// File: design/stream_queue.sv
// Single FIFO lane for stream beats with valid/ready on input and output.

`include "stream_macros.svh"

module stream_queue #(
    parameter int CAPACITY = `STREAM_QUEUE_CAPACITY
) (
    input  logic              aclk,
    input  logic              rst_n,
    // Write side.
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    // Read side.
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);
    import stream_pkg::*;

    localparam int PTR_W = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;
    localparam int CNT_W = $clog2(CAPACITY + 1);

    // ------------------------------
    // Storage and pointers
    // ------------------------------

    beat_t            mem [CAPACITY];  // Circular buffer.
    logic [PTR_W-1:0] rd_ptr;          // Head slot.
    logic [PTR_W-1:0] wr_ptr;          // Next free slot.
    logic [CNT_W-1:0] count;           // Beats stored.
    logic             open_q;          // Lane accepts beats once out of reset.

    logic push;
    logic pop;
    logic full;
    logic empty;

    // Pointer step with wrap, so any capacity works.
    function automatic logic [PTR_W-1:0] step_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(CAPACITY - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    // ------------------------------
    // Status and handshakes
    // ------------------------------

    assign full  = (count == CNT_W'(CAPACITY));
    assign empty = (count == '0);

    // A full lane still takes a beat when the head leaves in the same cycle.
    assign in_ready  = open_q && (!full || out_ready);
    assign out_valid = !empty;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Head beat comes straight from the storage registers.
    assign out_beat = mem[rd_ptr];

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            open_q <= 1'b0;
        end else begin
            open_q <= 1'b1;
            if (push) begin
                wr_ptr <= step_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= step_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);  // Write only.
                2'b01:   count <= count - CNT_W'(1);  // Read only.
                default: count <= count;              // Both or neither.
            endcase
        end
    end

    // ------------------------------
    // Beat storage
    // ------------------------------

    // When full, wr_ptr equals rd_ptr. The old head is read out this
    // cycle and the new beat lands in its slot on the same edge.
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule

// File: design/stream_queue_top.sv
// Top level with the destination router, the FIFO lanes and the packet arbiter.

`include "stream_macros.svh"

module stream_queue_top #(
    parameter int CAPACITY = `STREAM_QUEUE_CAPACITY
) (
    input  logic              aclk,
    input  logic              rst_n,
    // Receive stream.
    input  stream_pkg::beat_t rx_beat,
    input  logic              rx_tvalid,
    output logic              rx_tready,
    // Transmit stream.
    output stream_pkg::beat_t tx_beat,
    output logic              tx_tvalid,
    input  logic              tx_tready
);
    import stream_pkg::*;

    // ------------------------------
    // Internal wiring
    // ------------------------------

    beat_t              lane_beat;   // Shared beat toward all lanes.
    logic [lanes-1:0]   lane_valid;  // One-hot by tdest.
    logic [lanes-1:0]   lane_ready;

    beat_t [lanes-1:0]  q_beat;      // Lane heads.
    logic [lanes-1:0]   q_valid;
    logic [lanes-1:0]   q_ready;

    // ------------------------------
    // Router
    // ------------------------------

    stream_dest_router i_router (
        .rx_beat    (rx_beat),
        .rx_tvalid  (rx_tvalid),
        .rx_tready  (rx_tready),
        .lane_beat  (lane_beat),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

    // ------------------------------
    // Lanes
    // ------------------------------

    // One lane per destination.
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        stream_queue #(
            .CAPACITY (CAPACITY)
        ) i_queue (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .in_beat   (lane_beat),
            .in_valid  (lane_valid[i]),
            .in_ready  (lane_ready[i]),
            .out_beat  (q_beat[i]),
            .out_valid (q_valid[i]),
            .out_ready (q_ready[i])
        );
    end

    // ------------------------------
    // Arbiter
    // ------------------------------

    stream_packet_arbiter i_arbiter (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .q_beat    (q_beat),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .tx_beat   (tx_beat),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready)
    );

endmodule

// File: flist.f
+incdir+design
design/stream_pkg.sv
design/stream_queue.sv
design/stream_dest_router.sv
design/stream_packet_arbiter.sv
design/stream_queue_top.sv
sim/stream_queue_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module stream_queue_tb -Mdir obj_dir -f flist.f

status=0
output="$(./obj_dir/Vstream_queue_tb 2>&1)" || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Test completed successfully" <<< "$output"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: sim/stream_queue_tb.sv
// Testbench for the stream queue top level with random packets, a reference model and a watchdog.

`include "stream_macros.svh"

module stream_queue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import stream_pkg::*;

    localparam int PERIOD          = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int PACKETS         = 300;
    localparam int CAPACITY        = `STREAM_QUEUE_CAPACITY;
    localparam int DRAIN_CYCLES    = 400;
    localparam int WATCHDOG_CYCLES = PACKETS * 6 * 8 + DRAIN_CYCLES + 1000;
    localparam int BYTES           = `STREAM_TDATA_BYTES;
    localparam int DEST_W          = `STREAM_TDEST_WIDTH;
    localparam int USER_W          = `STREAM_TUSER_WIDTH;
    localparam int ID_W            = `STREAM_TID_WIDTH;
    localparam int TX_RANDOM       = 0;  // tx_tready low about a third of the time.
    localparam int TX_LOW          = 1;
    localparam int TX_HIGH         = 2;

    logic  aclk;
    logic  rst_n;
    beat_t rx_beat;
    logic  rx_tvalid;
    logic  rx_tready;
    beat_t tx_beat;
    logic  tx_tvalid;
    logic  tx_tready;

    beat_t             drv_beat;      // Beat to present at the next falling edge.
    logic              drv_valid;
    int                tx_mode;
    logic [15:0]       lfsr;
    logic              rx_xfer;       // Handshakes seen in the current cycle.
    logic              tx_xfer;
    logic              hold_pending;  // tx stalled last cycle.
    beat_t             held_beat;
    logic              pkt_open;      // A tx packet is in progress.
    logic [DEST_W-1:0] pkt_dest;
    logic [ID_W-1:0]   pkt_tid;
    beat_t             exp_q [lanes][$];  // Expected beats per destination.

    stream_queue_top #(
        .CAPACITY (CAPACITY)
    ) i_dut (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rx_beat   (rx_beat),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .tx_beat   (tx_beat),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready)
    );

    always #(PERIOD / 2) aclk = ~aclk;

    // ------------------------------
    // Random source
    // ------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;  // Galois taps 16, 14, 13, 11.
        end
        return n;
    endfunction

    // One step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int packet_len();
        int len;
        do begin
            len = int'(rand_bits(3));
        end while (len > 5);
        return len + 1;
    endfunction

    function automatic beat_t make_beat(input logic [DEST_W-1:0] dest,
                                        input logic [ID_W-1:0] tid, input logic last);
        beat_t b;
        for (int i = 0; i < BYTES; i++) begin
            b.tdata[i] = 8'(rand_bits(8));
        end
        b.tkeep = BYTES'(rand_bits(BYTES));
        b.tlast = last;
        b.tdest = dest;
        b.tuser = USER_W'(rand_bits(USER_W));
        b.tid   = tid;
        return b;
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t want);
        if (got !== want) begin
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, want);
            abort_run();
        end
    endtask

    function automatic logic queues_empty();
        logic e;
        e = 1'b1;
        for (int d = 0; d < lanes; d++) begin
            if (exp_q[d].size() != 0) e = 1'b0;
        end
        return e;
    endfunction

    // Sampled mid-cycle, one time unit after the falling edge.
    task automatic observe_cycle();
        beat_t want;
        rx_xfer = rx_tvalid && rx_tready;
        tx_xfer = tx_tvalid && tx_tready;
        if (hold_pending) begin
            check_bit("tx_tvalid", tx_tvalid, 1'b1);
            check_beat("tx_beat", tx_beat, held_beat);
        end
        if (rx_xfer) exp_q[rx_beat.tdest].push_back(rx_beat);
        if (tx_xfer) begin
            if (exp_q[tx_beat.tdest].size() == 0) begin
                $display("At %0d ns a tx beat arrived with nothing pending for tdest %0d",
                         $time, tx_beat.tdest);
                abort_run();
            end
            want = exp_q[tx_beat.tdest].pop_front();
            check_beat("tx_beat", tx_beat, want);
            if (pkt_open && (tx_beat.tdest !== pkt_dest || tx_beat.tid !== pkt_tid)) begin
                $display("At %0d ns a beat of another packet came out before tlast", $time);
                abort_run();
            end
            pkt_open = !tx_beat.tlast;
            pkt_dest = tx_beat.tdest;
            pkt_tid  = tx_beat.tid;
        end
        hold_pending = tx_tvalid && !tx_tready;
        held_beat    = tx_beat;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic run_cycle();
        @(negedge aclk);
        rx_beat   = drv_beat;
        rx_tvalid = drv_valid;
        case (tx_mode)
            TX_LOW:  tx_tready = 1'b0;
            TX_HIGH: tx_tready = 1'b1;
            default: tx_tready = (rand_bits(3) >= 3);
        endcase
        #1;
        observe_cycle();
    endtask

    // Beat stays on the bus until the lane takes it.
    task automatic send_beat(input beat_t b);
        drv_beat  = b;
        drv_valid = 1'b1;
        do begin
            run_cycle();
        end while (!rx_xfer);
    endtask

    task automatic send_packet(input logic [DEST_W-1:0] dest, input int len);
        logic [ID_W-1:0] tid;
        tid = ID_W'(rand_bits(ID_W));
        for (int i = 0; i < len; i++) begin
            send_beat(make_beat(dest, tid, i == len - 1));
        end
        drv_valid = 1'b0;
    endtask

    // Fill one lane with tx stalled, then probe it and a neighbour.
    task automatic capacity_test();
        logic [DEST_W-1:0] dest;
        logic [ID_W-1:0]   tid;
        dest      = DEST_W'(rand_bits(DEST_W));
        tid       = ID_W'(rand_bits(ID_W));
        tx_mode   = TX_LOW;
        drv_valid = 1'b1;
        for (int i = 0; i < CAPACITY; i++) begin
            drv_beat = make_beat(dest, tid, i == CAPACITY - 1);
            run_cycle();
            check_bit("rx_tready", rx_tready, 1'b1);
        end
        drv_valid = 1'b0;  // Ready is probed with the full lane's tdest still shown.
        run_cycle();
        check_bit("rx_tready", rx_tready, 1'b0);
        drv_beat  = make_beat(dest + DEST_W'(1), tid, 1'b1);
        drv_valid = 1'b1;
        run_cycle();
        check_bit("rx_tready", rx_tready, 1'b1);
        drv_valid = 1'b0;
        tx_mode   = TX_RANDOM;
    endtask

    task automatic drain();
        int n;
        n         = 0;
        drv_valid = 1'b0;
        tx_mode   = TX_HIGH;
        while ((!queues_empty() || tx_tvalid) && n < DRAIN_CYCLES) begin
            run_cycle();
            n++;
        end
        repeat (4) run_cycle();
        check_bit("tx_tvalid", tx_tvalid, 1'b0);
        for (int d = 0; d < lanes; d++) begin
            check_count("expected beats left", exp_q[d].size(), 0);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        logic [DEST_W-1:0] dest;
        int                len;
        aclk         = 1'b0;
        rst_n        = 1'b0;
        rx_beat      = '0;
        rx_tvalid    = 1'b0;
        tx_tready    = 1'b0;
        drv_beat     = '0;
        drv_valid    = 1'b0;
        tx_mode      = TX_RANDOM;
        lfsr         = 16'd16505;
        hold_pending = 1'b0;
        held_beat    = '0;
        pkt_open     = 1'b0;
        pkt_dest     = '0;
        pkt_tid      = '0;
        repeat (RESET_CYCLES) begin
            @(posedge aclk);
            #1;
            check_bit("tx_tvalid", tx_tvalid, 1'b0);
            check_bit("rx_tready", rx_tready, 1'b0);
        end
        @(negedge aclk);
        rst_n = 1'b1;
        #1;
        check_bit("tx_tvalid", tx_tvalid, 1'b0);
        run_cycle();
        check_bit("tx_tvalid", tx_tvalid, 1'b0);
        check_bit("rx_tready", rx_tready, 1'b1);
        capacity_test();
        for (int p = 0; p < PACKETS; p++) begin
            dest = DEST_W'(rand_bits(DEST_W));
            len  = packet_len();
            send_packet(dest, len);
            repeat (int'(rand_bits(2))) run_cycle();  // Idle gap of 0 to 3 cycles.
        end
        drain();
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles before the run finished", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule
